/* hw/conv_pkg.sv */
package conv_pkg;

    // Pixel and coefficient words are signed fixed-point integers
    localparam int data_width = 16;
    localparam int coef_width = 16;

    // Kernel window geometry
    localparam int kx = 3;
    localparam int ky = 3;
    localparam int taps = kx * ky;

    localparam int num_kernels = 4;

    // Physical row length of the line buffer
    localparam int max_xres = 32;

    // Selectable row widths, indexed by xres_select
    localparam int num_res = 3;
    localparam int xres_table [num_res] = '{8, 16, 32};
    localparam int sel_width = 2;

    // Full-width arithmetic, sized so that no sum can overflow
    localparam int prod_width = data_width + coef_width;
    localparam int acc_width = prod_width + 4;
    localparam int result_width = acc_width + 2;

    // Pipeline depths, counted from the enable_calc edge
    localparam int mac_latency = 2;
    localparam int sum_latency = 1;

endpackage

/* hw/window_buffer.sv */
`timescale 1ns/10ps

module window_buffer (
    input  logic                                           clock,
    input  logic                                           data_shift,
    input  logic [conv_pkg::data_width-1:0]                data,
    input  logic [conv_pkg::sel_width-1:0]                 xres_select,
    output logic [conv_pkg::taps*conv_pkg::data_width-1:0] window
);

    // Row y, column x of the line buffer
    logic [conv_pkg::data_width-1:0] rows [conv_pkg::ky][conv_pkg::max_xres];

    // Candidate row-end words for every selectable width, one set per feeding row
    logic [conv_pkg::num_res-1:0][conv_pkg::data_width-1:0] row_taps [conv_pkg::ky-1];

    // Word that enters column 0 of the next row
    logic [conv_pkg::data_width-1:0] row_end [conv_pkg::ky-1];

    always_comb begin
        for (int y = 0; y < conv_pkg::ky - 1; y++) begin
            for (int r = 0; r < conv_pkg::num_res; r++) begin
                row_taps[y][r] = rows[y][conv_pkg::xres_table[r] - 1];
            end
        end
    end

    // Select values past the table fall back to the full physical row
    always_comb begin
        for (int y = 0; y < conv_pkg::ky - 1; y++) begin
            if (xres_select < conv_pkg::sel_width'(conv_pkg::num_res)) begin
                row_end[y] = row_taps[y][xres_select];
            end else begin
                row_end[y] = rows[y][conv_pkg::max_xres - 1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (data_shift) begin
            rows[0][0] <= data;
            for (int y = 1; y < conv_pkg::ky; y++) begin
                rows[y][0] <= row_end[y - 1];
            end
            for (int y = 0; y < conv_pkg::ky; y++) begin
                for (int x = 1; x < conv_pkg::max_xres; x++) begin
                    rows[y][x] <= rows[y][x - 1];
                end
            end
        end
    end

    // The window is the leftmost kx columns of every row
    always_comb begin
        for (int y = 0; y < conv_pkg::ky; y++) begin
            for (int x = 0; x < conv_pkg::kx; x++) begin
                window[(x + y * conv_pkg::kx) * conv_pkg::data_width +: conv_pkg::data_width] =
                    rows[y][x];
            end
        end
    end

endmodule

/* hw/kernel_mac.sv */
`timescale 1ns/10ps

module kernel_mac (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           kernel_shift,
    input  logic [conv_pkg::coef_width-1:0]                coef_in,
    output logic [conv_pkg::coef_width-1:0]                coef_out,
    input  logic                                           enable_calc,
    input  logic [conv_pkg::taps*conv_pkg::data_width-1:0] window,
    output logic                                           mac_valid,
    output logic [conv_pkg::acc_width-1:0]                 mac_sum
);

    logic signed [conv_pkg::coef_width-1:0] coef [conv_pkg::taps];
    logic signed [conv_pkg::prod_width-1:0] products [conv_pkg::taps];
    logic signed [conv_pkg::acc_width-1:0]  product_total;
    logic [conv_pkg::mac_latency-1:0]       valid_pipe;

    // Coefficient segment of the serial load chain
    always_ff @(posedge clock) begin
        if (kernel_shift) begin
            coef[0] <= coef_in;
            for (int i = 1; i < conv_pkg::taps; i++) begin
                coef[i] <= coef[i - 1];
            end
        end
    end

    assign coef_out = coef[conv_pkg::taps - 1];

    // Stage one captures window and coefficients at the enable edge
    always_ff @(posedge clock) begin
        if (enable_calc) begin
            for (int i = 0; i < conv_pkg::taps; i++) begin
                products[i] <=
                    $signed(window[i * conv_pkg::data_width +: conv_pkg::data_width]) * coef[i];
            end
        end
    end

    // Nine products sign-extended into the wider accumulator
    always_comb begin
        product_total = '0;
        for (int i = 0; i < conv_pkg::taps; i++) begin
            product_total = product_total + products[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[conv_pkg::mac_latency-2:0], enable_calc};
        end
    end

    // Stage two holds the sum of products
    always_ff @(posedge clock) begin
        if (valid_pipe[0]) begin
            mac_sum <= product_total;
        end
    end

    assign mac_valid = valid_pipe[conv_pkg::mac_latency - 1];

endmodule

/* hw/channel_sum.sv */
`timescale 1ns/10ps

module channel_sum (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic [conv_pkg::num_kernels-1:0]                     mac_valid,
    input  logic [conv_pkg::num_kernels*conv_pkg::acc_width-1:0] mac_sum,
    output logic                                                 result_valid,
    output logic [conv_pkg::result_width-1:0]                    result
);

    logic signed [conv_pkg::result_width-1:0] kernel_total;

    always_comb begin
        kernel_total = '0;
        for (int k = 0; k < conv_pkg::num_kernels; k++) begin
            kernel_total = kernel_total +
                $signed(mac_sum[k * conv_pkg::acc_width +: conv_pkg::acc_width]);
        end
    end

    // Every unit runs in lockstep so unit 0 speaks for all of them
    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mac_valid[0];
        end
    end

    always_ff @(posedge clock) begin
        if (mac_valid[0]) begin
            result <= kernel_total;
        end
    end

endmodule

/* hw/conv_engine.sv */
`timescale 1ns/10ps

module conv_engine (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [conv_pkg::sel_width-1:0]     xres_select,
    input  logic                               kernel_shift,
    input  logic [conv_pkg::coef_width-1:0]    kernel_data,
    input  logic                               data_shift,
    input  logic [conv_pkg::data_width-1:0]    data,
    input  logic                               enable_calc,
    output logic                               result_valid,
    output logic [conv_pkg::result_width-1:0]  result
);

    logic [conv_pkg::taps*conv_pkg::data_width-1:0]        window;
    logic [conv_pkg::num_kernels-1:0][conv_pkg::coef_width-1:0] coef_link;
    logic [conv_pkg::num_kernels-1:0]                      mac_valid;
    logic [conv_pkg::num_kernels*conv_pkg::acc_width-1:0]  mac_sum;

    window_buffer u_window_buffer (
        .clock       (clock),
        .data_shift  (data_shift),
        .data        (data),
        .xres_select (xres_select),
        .window      (window)
    );

    // Coefficients ripple from kernel 0 toward the last kernel
    for (genvar k = 0; k < conv_pkg::num_kernels; k++) begin : g_kernel
        kernel_mac u_kernel_mac (
            .clock        (clock),
            .reset        (reset),
            .kernel_shift (kernel_shift),
            .coef_in      ((k == 0) ? kernel_data : coef_link[(k == 0) ? 0 : k - 1]),
            .coef_out     (coef_link[k]),
            .enable_calc  (enable_calc),
            .window       (window),
            .mac_valid    (mac_valid[k]),
            .mac_sum      (mac_sum[k * conv_pkg::acc_width +: conv_pkg::acc_width])
        );
    end

    channel_sum u_channel_sum (
        .clock        (clock),
        .reset        (reset),
        .mac_valid    (mac_valid),
        .mac_sum      (mac_sum),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* tb/conv_engine_asserts.sv */
`timescale 1ns/10ps

module conv_engine_asserts (
    input logic                               clock,
    input logic                               reset,
    input logic                               enable_calc,
    input logic                               result_valid,
    input logic [conv_pkg::result_width-1:0]  result
);

    // Every enable cycle is answered three cycles later, once
    valid_follows_enable: assert property (
        @(posedge clock) disable iff (reset)
        !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
            |-> result_valid == $past(enable_calc, 3)
    ) else $error("result_valid does not follow enable_calc by three cycles");

    // Nothing can be in flight while reset holds or right after it
    quiet_after_reset: assert property (
        @(posedge clock)
        $past(reset, 1) || $past(reset, 2) || $past(reset, 3) |-> !result_valid
    ) else $error("result_valid high during or just after reset");

    result_known: assert property (
        @(posedge clock) disable iff (reset)
        result_valid |-> !$isunknown(result)
    ) else $error("result holds unknown bits while result_valid is high");

endmodule

/* tb/conv_engine_tb.sv */
`timescale 1ns/10ps

module conv_engine_tb;

    localparam int clock_period = 4;
    localparam int reset_cycles = 5;
    localparam int latency = conv_pkg::mac_latency + conv_pkg::sum_latency;
    localparam int chain_len = conv_pkg::num_kernels * conv_pkg::taps;
    localparam int num_rows = 8;

    // Value modes for coefficients and pixels
    localparam int mode_small = 0;
    localparam int mode_full = 1;
    localparam int mode_extreme = 2;
    localparam int mode_single = 3;

    typedef struct packed {
        int sel;
        int mode;
        int tap;
        int shifts;
        int enables;
        bit shift_during;
    } stim_row_t;

    // xres_select, value mode, flat chain index of the lone coefficient,
    // pixel shifts, enable cycles, data_shift during the enables
    localparam stim_row_t stim_table [num_rows] = '{
        '{0, mode_single,  4, 24, 4, 1'b1},
        '{1, mode_single, 26, 40, 3, 1'b1},
        '{0, mode_small,   0, 20, 6, 1'b0},
        '{1, mode_small,   0, 36, 6, 1'b1},
        '{2, mode_full,    0, 70, 8, 1'b1},
        '{3, mode_full,    0, 67, 5, 1'b0},
        '{2, mode_extreme, 0, 68, 6, 1'b1},
        '{0, mode_full,    0, 19, 10, 1'b1}
    };

    logic                               clock;
    logic                               reset;
    logic [conv_pkg::sel_width-1:0]     xres_select;
    logic                               kernel_shift;
    logic [conv_pkg::coef_width-1:0]    kernel_data;
    logic                               data_shift;
    logic [conv_pkg::data_width-1:0]    data;
    logic                               enable_calc;
    logic                               result_valid;
    logic [conv_pkg::result_width-1:0]  result;

    // Behavioral copy of the line buffer and the coefficient chain
    logic signed [conv_pkg::data_width-1:0] pixel_model [conv_pkg::ky][conv_pkg::max_xres];
    logic signed [conv_pkg::coef_width-1:0] coef_model [chain_len];
    logic [conv_pkg::result_width-1:0]      expected_q [$];
    logic [latency-1:0]                     enable_hist;

    conv_engine u_dut (
        .clock        (clock),
        .reset        (reset),
        .xres_select  (xres_select),
        .kernel_shift (kernel_shift),
        .kernel_data  (kernel_data),
        .data_shift   (data_shift),
        .data         (data),
        .enable_calc  (enable_calc),
        .result_valid (result_valid),
        .result       (result)
    );

    bind conv_engine conv_engine_asserts u_asserts (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input logic [conv_pkg::result_width-1:0] actual,
                                input logic [conv_pkg::result_width-1:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL result: got 0x%h expected 0x%h", actual, expected));
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL result_valid: got 0x%h expected 0x%h",
                                     actual, expected));
        end
    endtask

    function automatic int row_width(input int sel);
        if (sel < conv_pkg::num_res) begin
            return conv_pkg::xres_table[sel];
        end
        return conv_pkg::max_xres;
    endfunction

    function automatic logic [conv_pkg::data_width-1:0] random_word(input int mode);
        case (mode)
            mode_full: return conv_pkg::data_width'($urandom);
            mode_extreme: return ($urandom_range(0, 1) == 1) ? 16'h7fff : 16'h8000;
            default: return conv_pkg::data_width'($urandom_range(0, 4094) - 2047);
        endcase
    endfunction

    // Sum over kernels and taps of coefficient times window word
    function automatic logic [conv_pkg::result_width-1:0] model_result();
        longint acc;
        acc = 0;
        for (int k = 0; k < conv_pkg::num_kernels; k++) begin
            for (int i = 0; i < conv_pkg::taps; i++) begin
                acc += longint'(coef_model[k * conv_pkg::taps + i]) *
                       longint'(pixel_model[i / conv_pkg::kx][i % conv_pkg::kx]);
            end
        end
        return acc[conv_pkg::result_width-1:0];
    endfunction

    task automatic shift_coef_model(input logic [conv_pkg::coef_width-1:0] word);
        for (int j = chain_len - 1; j > 0; j--) begin
            coef_model[j] = coef_model[j - 1];
        end
        coef_model[0] = word;
    endtask

    task automatic shift_pixel_model(input logic [conv_pkg::data_width-1:0] word);
        logic signed [conv_pkg::data_width-1:0] row_end [conv_pkg::ky - 1];
        int width;
        width = row_width(int'(xres_select));
        for (int y = 0; y < conv_pkg::ky - 1; y++) begin
            row_end[y] = pixel_model[y][width - 1];
        end
        for (int y = 0; y < conv_pkg::ky; y++) begin
            for (int x = conv_pkg::max_xres - 1; x > 0; x--) begin
                pixel_model[y][x] = pixel_model[y][x - 1];
            end
        end
        pixel_model[0][0] = word;
        for (int y = 1; y < conv_pkg::ky; y++) begin
            pixel_model[y][0] = row_end[y - 1];
        end
    endtask

    // The enable is scored against the model state before this cycle's shifts land
    task automatic drive_cycle(input logic ks, input logic [conv_pkg::coef_width-1:0] kd,
                               input logic ds, input logic [conv_pkg::data_width-1:0] d,
                               input logic en);
        @(posedge clock);
        #1;
        if (en) begin
            expected_q.push_back(model_result());
        end
        if (ks) begin
            shift_coef_model(kd);
        end
        if (ds) begin
            shift_pixel_model(d);
        end
        kernel_shift = ks;
        kernel_data = kd;
        data_shift = ds;
        data = d;
        enable_calc = en;
    endtask

    task automatic select_width(input int sel);
        @(posedge clock);
        #1;
        xres_select = conv_pkg::sel_width'(sel);
    endtask

    task automatic run_row(input stim_row_t row);
        logic [conv_pkg::coef_width-1:0] word;
        int pixel_mode;
        pixel_mode = (row.mode == mode_single) ? mode_small : row.mode;
        select_width(row.sel);
        // Load word n ends up at flat chain index chain_len - 1 - n
        for (int n = 0; n < chain_len; n++) begin
            if (row.mode == mode_single) begin
                word = '0;
                if (chain_len - 1 - n == row.tap) begin
                    word = random_word(mode_small);
                    if (word == '0) begin
                        word = 1;
                    end
                end
            end else begin
                word = random_word(row.mode);
            end
            drive_cycle(1'b1, word, 1'b0, '0, 1'b0);
        end
        for (int s = 0; s < row.shifts; s++) begin
            drive_cycle(1'b0, '0, 1'b1, random_word(pixel_mode), 1'b0);
        end
        for (int e = 0; e < row.enables; e++) begin
            drive_cycle(1'b0, '0, row.shift_during, random_word(pixel_mode), 1'b1);
        end
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);
        while (expected_q.size() != 0) begin
            drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            enable_hist <= '0;
        end else begin
            enable_hist <= {enable_hist[latency-2:0], enable_calc};
        end
    end

    // Outputs settle after the rising edge, so they are scored on the falling edge
    always @(negedge clock) begin
        check_valid(result_valid, enable_hist[latency-1]);
        if (result_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                report_failure("result_valid went high with no result pending");
            end else begin
                check_result(result, expected_q.pop_front());
            end
        end
    end

    initial begin
        int limit;
        limit = reset_cycles;
        for (int r = 0; r < num_rows; r++) begin
            limit += chain_len + stim_table[r].shifts + stim_table[r].enables + 10;
        end
        #(limit * clock_period * 2);
        report_failure("Watchdog expired before the stimulus table finished");
    end

    initial begin
        void'($urandom(32'hd55));
        reset = 1'b1;
        xres_select = '0;
        kernel_shift = 1'b0;
        kernel_data = '0;
        data_shift = 1'b0;
        data = '0;
        enable_calc = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            run_row(stim_table[r]);
        end
        repeat (latency + 2) @(posedge clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* list.f */
hw/conv_pkg.sv
hw/window_buffer.sv
hw/kernel_mac.sv
hw/channel_sum.sv
hw/conv_engine.sv
tb/conv_engine_asserts.sv
tb/conv_engine_tb.sv
